// File: Bender.yml
package:
  name: jpeg_quant

sources:
  - include_dirs:
      - source
    files:
      - source/jpeg_quant_pkg.sv
      - source/zigzag_buffer.sv
      - source/mcu_tracker.sv
      - source/quant_tables.sv
      - source/quant_mult_pipe.sv
      - source/quant.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/quant_tb.sv

// File: build.f
+incdir+source
+incdir+tb
source/jpeg_quant_pkg.sv
source/zigzag_buffer.sv
source/mcu_tracker.sv
source/quant_tables.sv
source/quant_mult_pipe.sv
source/quant.sv
tb/quant_tb.sv

// File: source/jpeg_quant_macros.svh
// jpeg quantizer widths, product shift and frame size limits
`ifndef JPEG_QUANT_MACROS_SVH
`define JPEG_QUANT_MACROS_SVH

// dct coefficient and quantized output widths
`define JQ_DW 15
`define JQ_QW 11

// reciprocal factor width and the right shift applied to each product
`define JQ_MBITS 13
`define JQ_SHIFT 12

// largest frame the mcu counters have to cover
`define JQ_MAX_X 720
`define JQ_MAX_Y 720

// widths of the programmed frame size fields
`define JQ_XW $clog2(`JQ_MAX_X)
`define JQ_YW $clog2(`JQ_MAX_Y)

`endif

// File: source/jpeg_quant_pkg.sv
// jpeg quantizer data types, block tag, zig-zag mapping and base tables
`include "jpeg_quant_macros.svh"

package jpeg_quant_pkg;

    typedef logic signed [`JQ_DW-1:0] coef_t;
    typedef logic signed [`JQ_QW-1:0] qcoef_t;
    typedef logic [`JQ_MBITS-1:0] qfactor_t;

    // one dct column, row 0 in the low slot
    typedef coef_t [7:0] col_t;
    typedef coef_t [1:0] pair_t;
    typedef qcoef_t [1:0] qpair_t;

    typedef enum logic [1:0] {
        PLANE_Y = 2'd0,
        PLANE_U = 2'd1,
        PLANE_V = 2'd2
    } plane_e;

    typedef struct packed {
        logic       last_mcu;
        plane_e     plane;
        logic [4:0] pair_idx;
    } blk_tag_t;

    // raster position (row*8 + col) to zig-zag rank
    function automatic logic [5:0] zz_rank(input logic [5:0] pos);
        int r;
        int c;
        int s;
        int n;
        r = int'(pos[5:3]);
        c = int'(pos[2:0]);
        s = r + c;
        // odd diagonals run down the rows, even ones run up
        if (s < 8)
            n = s * (s + 1) / 2 + ((s % 2 == 1) ? r : c);
        else
            n = 64 - (15 - s) * (16 - s) / 2 + ((s % 2 == 1) ? 7 - c : 7 - r);
        return 6'(n);
    endfunction

    // zig-zag rank back to raster position
    function automatic logic [5:0] zz_pos(input logic [5:0] rank);
        logic [5:0] pos;
        pos = '0;
        for (int p = 0; p < 64; p++) begin
            if (zz_rank(6'(p)) == rank)
                pos = 6'(p);
        end
        return pos;
    endfunction

    // annex k base tables, raster order
    localparam logic [7:0] luma_base [64] = '{
        16, 11, 10, 16, 24, 40, 51, 61,      12, 12, 14, 19, 26, 58, 60, 55,
        14, 13, 16, 24, 40, 57, 69, 56,      14, 17, 22, 29, 51, 87, 80, 62,
        18, 22, 37, 56, 68, 109, 103, 77,    24, 35, 55, 64, 81, 104, 113, 92,
        49, 64, 78, 87, 103, 121, 120, 101,  72, 92, 95, 98, 112, 100, 103, 99
    };

    localparam logic [7:0] chroma_base [64] = '{
        17, 18, 24, 47, 99, 99, 99, 99,      18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,      47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,      99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,      99, 99, 99, 99, 99, 99, 99, 99
    };

endpackage

// File: source/mcu_tracker.sv
// 4:2:0 mcu position tracker, gives plane and last-mcu for the block being read
`timescale 1ns/10ps
`include "jpeg_quant_macros.svh"

module mcu_tracker (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   blk_done,
    input  logic [`JQ_XW-1:0]      x_size_m1,
    input  logic [`JQ_YW-1:0]      y_size_m1,
    output jpeg_quant_pkg::plane_e plane,
    output logic                   last_mcu
);

    logic [2:0]         blk_cnt;
    logic [`JQ_XW-5:0]  x_mcu;
    logic [`JQ_YW-5:0]  y_mcu;
    logic               x_end;
    logic               y_end;

    // mcu counts are the frame size in 16 pixel units
    assign x_end = (x_mcu == x_size_m1[`JQ_XW-1:4]);
    assign y_end = (y_mcu == y_size_m1[`JQ_YW-1:4]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            blk_cnt <= '0;
            x_mcu   <= '0;
            y_mcu   <= '0;
        end else if (blk_done) begin
            if (blk_cnt == 3'd5) begin
                blk_cnt <= '0;
                x_mcu   <= x_end ? '0 : x_mcu + 1'b1;
                if (x_end)
                    y_mcu <= y_end ? '0 : y_mcu + 1'b1;
            end else begin
                blk_cnt <= blk_cnt + 3'd1;
            end
        end
    end

    always_comb begin
        case (blk_cnt)
            3'd4:    plane = jpeg_quant_pkg::PLANE_U;
            3'd5:    plane = jpeg_quant_pkg::PLANE_V;
            default: plane = jpeg_quant_pkg::PLANE_Y;
        endcase
    end

    assign last_mcu = (blk_cnt == 3'd5) && x_end && y_end;

endmodule

// File: source/quant.sv
// jpeg coefficient quantizer top, zig-zag reorder, table scaling and block tags
`timescale 1ns/10ps
`include "jpeg_quant_macros.svh"

module quant (
    input  logic                        clk,
    input  logic                        resetn,
    input  jpeg_quant_pkg::col_t        di,
    input  logic                        di_valid,
    input  logic [2:0]                  di_cnt,
    output logic                        di_hold,
    output jpeg_quant_pkg::qpair_t      q,
    output logic                        q_valid,
    input  logic                        q_hold,
    output jpeg_quant_pkg::blk_tag_t    q_tag,
    input  logic [`JQ_XW-1:0]           x_size_m1,
    input  logic [`JQ_YW-1:0]           y_size_m1
);

    logic                           rd_adv;
    logic                           rd_valid;
    jpeg_quant_pkg::pair_t          rd_pair;
    logic [4:0]                     rd_idx;
    logic                           blk_done;
    jpeg_quant_pkg::plane_e         plane;
    logic                           last_mcu;
    logic [1:0][5:0]                ra;
    jpeg_quant_pkg::qfactor_t [1:0] factor;

    // stage register, in step with the factor register
    jpeg_quant_pkg::pair_t          st_pair;
    jpeg_quant_pkg::blk_tag_t       st_tag;
    logic                           st_valid;

    assign rd_adv = !q_hold;

    zigzag_buffer zigzag_buffer_inst (
        .clk      (clk),
        .resetn   (resetn),
        .di       (di),
        .di_valid (di_valid),
        .di_cnt   (di_cnt),
        .di_hold  (di_hold),
        .rd_adv   (rd_adv),
        .rd_valid (rd_valid),
        .rd_pair  (rd_pair),
        .rd_idx   (rd_idx),
        .blk_done (blk_done)
    );

    mcu_tracker mcu_tracker_inst (
        .clk       (clk),
        .resetn    (resetn),
        .blk_done  (blk_done),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .plane     (plane),
        .last_mcu  (last_mcu)
    );

    // raster addresses of zig-zag slots 2k and 2k+1
    always_comb begin
        for (int j = 0; j < 2; j++)
            ra[j] = jpeg_quant_pkg::zz_pos({rd_idx, 1'(j)});
    end

    quant_tables quant_tables_inst (
        .clk    (clk),
        .re     (rd_valid && rd_adv),
        .chroma (plane != jpeg_quant_pkg::PLANE_Y),
        .ra     (ra),
        .rd     (factor)
    );

    always_ff @(posedge clk) begin
        if (!resetn)
            st_valid <= 1'b0;
        else if (!q_hold)
            st_valid <= rd_valid;
    end

    always_ff @(posedge clk) begin
        if (rd_valid && !q_hold) begin
            st_pair <= rd_pair;
            st_tag  <= '{last_mcu: last_mcu, plane: plane, pair_idx: rd_idx};
        end
    end

    quant_mult_pipe quant_mult_pipe_inst (
        .clk       (clk),
        .resetn    (resetn),
        .en        (!q_hold),
        .in_valid  (st_valid),
        .a_in      (st_pair),
        .b_in      (factor),
        .tag_in    (st_tag),
        .out_pair  (q),
        .out_tag   (q_tag),
        .out_valid (q_valid)
    );

endmodule

// File: source/quant_mult_pipe.sv
// two-lane 4-stage signed x unsigned multiplier with shift, valid and tag lanes
`timescale 1ns/10ps
`include "jpeg_quant_macros.svh"

module quant_mult_pipe (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            en,
    input  logic                            in_valid,
    input  jpeg_quant_pkg::pair_t           a_in,
    input  jpeg_quant_pkg::qfactor_t [1:0]  b_in,
    input  jpeg_quant_pkg::blk_tag_t        tag_in,
    output jpeg_quant_pkg::qpair_t          out_pair,
    output jpeg_quant_pkg::blk_tag_t        out_tag,
    output logic                            out_valid
);

    // factor split into low and high slices for the partial products
    localparam int lb  = 7;
    localparam int hb  = `JQ_MBITS - lb;
    localparam int pw  = `JQ_DW + `JQ_MBITS + 1;

    jpeg_quant_pkg::pair_t              a1;
    jpeg_quant_pkg::qfactor_t [1:0]     b1;
    logic signed [`JQ_DW+lb:0]          lo2 [2];
    logic signed [`JQ_DW+hb:0]          hi2 [2];
    logic signed [pw-1:0]               prod3 [2];
    jpeg_quant_pkg::blk_tag_t           tag_sr [4];
    logic [3:0]                         vld_sr;

    always_ff @(posedge clk) begin
        if (!resetn)
            vld_sr <= '0;
        else if (en)
            vld_sr <= {vld_sr[2:0], in_valid};
    end

    always_ff @(posedge clk) begin
        if (en) begin
            a1 <= a_in;
            b1 <= b_in;
            for (int j = 0; j < 2; j++) begin
                lo2[j]      <= a1[j] * $signed({1'b0, b1[j][lb-1:0]});
                hi2[j]      <= a1[j] * $signed({1'b0, b1[j][`JQ_MBITS-1:lb]});
                prod3[j]    <= (hi2[j] <<< lb) + lo2[j];
                // arithmetic shift then truncate to the output width
                out_pair[j] <= prod3[j][`JQ_SHIFT +: `JQ_QW];
            end
            tag_sr[0] <= tag_in;
            for (int i = 1; i < 4; i++)
                tag_sr[i] <= tag_sr[i-1];
        end
    end

    assign out_tag   = tag_sr[3];
    assign out_valid = vld_sr[3];

    hold_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        !en |=> ($stable(out_pair) && $stable(out_valid) && $stable(out_tag))
    );

endmodule

// File: source/quant_tables.sv
// reciprocal quantization factor rom, two registered lookups per cycle
`timescale 1ns/10ps
`include "jpeg_quant_macros.svh"

module quant_tables (
    input  logic                            clk,
    input  logic                            re,
    input  logic                            chroma,
    input  logic [1:0][5:0]                 ra,
    output jpeg_quant_pkg::qfactor_t [1:0]  rd
);

    typedef jpeg_quant_pkg::qfactor_t rom_t [64];

    // 2^shift divided by the base entry, rounded to nearest
    function automatic rom_t build_rom(input logic sel_chroma);
        rom_t rom;
        int   b;
        for (int p = 0; p < 64; p++) begin
            if (sel_chroma)
                b = int'(jpeg_quant_pkg::chroma_base[p]);
            else
                b = int'(jpeg_quant_pkg::luma_base[p]);
            rom[p] = jpeg_quant_pkg::qfactor_t'(((1 << `JQ_SHIFT) + b / 2) / b);
        end
        return rom;
    endfunction

    localparam rom_t luma_rom   = build_rom(1'b0);
    localparam rom_t chroma_rom = build_rom(1'b1);

    // both lanes share the table row selected by chroma
    always_ff @(posedge clk) begin
        if (re) begin
            for (int j = 0; j < 2; j++) begin
                if (chroma)
                    rd[j] <= chroma_rom[ra[j]];
                else
                    rd[j] <= luma_rom[ra[j]];
            end
        end
    end

endmodule

// File: source/zigzag_buffer.sv
// zig-zag block store, column writes in reverse zig-zag and paired zig-zag reads
`timescale 1ns/10ps

module zigzag_buffer (
    input  logic                 clk,
    input  logic                 resetn,
    input  jpeg_quant_pkg::col_t di,
    input  logic                 di_valid,
    input  logic [2:0]           di_cnt,
    output logic                 di_hold,
    input  logic                 rd_adv,
    output logic                 rd_valid,
    output jpeg_quant_pkg::pair_t rd_pair,
    output logic [4:0]           rd_idx,
    output logic                 blk_done
);

    typedef enum logic {
        MODE_WR = 1'b0,
        MODE_RD = 1'b1
    } mode_e;

    jpeg_quant_pkg::coef_t mem [64];
    mode_e                 mode;
    logic [4:0]            rd_cnt;
    logic                  wr_acc;
    logic                  rd_step;
    logic [2:0]            exp_cnt;

    assign wr_acc  = (mode == MODE_WR) && di_valid;
    assign rd_step = (mode == MODE_RD) && rd_adv;

    assign di_hold  = (mode == MODE_RD);
    assign rd_valid = (mode == MODE_RD);
    assign rd_idx   = rd_cnt;
    // last pair of the block leaves the buffer
    assign blk_done = rd_step && (&rd_cnt);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mode   <= MODE_WR;
            rd_cnt <= '0;
        end else if (rd_step) begin
            rd_cnt <= rd_cnt + 5'd1;
            if (&rd_cnt)
                mode <= MODE_WR;
        end else if (wr_acc && (&di_cnt)) begin
            mode <= MODE_RD;
        end
    end

    // row r of column c lands on the zig-zag rank of raster slot r*8+c
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            for (int r = 0; r < 8; r++)
                mem[jpeg_quant_pkg::zz_rank({3'(r), di_cnt})] <= di[r];
        end
    end

    // slots are already in zig-zag order, so beat k is slots 2k and 2k+1
    always_comb begin
        rd_pair[0] = mem[{rd_cnt, 1'b0}];
        rd_pair[1] = mem[{rd_cnt, 1'b1}];
    end

    // expected column index of the next accepted column
    always_ff @(posedge clk) begin
        if (!resetn)
            exp_cnt <= '0;
        else if (wr_acc)
            exp_cnt <= exp_cnt + 3'd1;
    end

    col_order: assert property (
        @(posedge clk) disable iff (!resetn)
        wr_acc |-> (di_cnt == exp_cnt)
    );

endmodule

// File: tb/quant_model.svh
// quantizer reference model, expected coefficient and tag of each output beat
`ifndef QUANT_MODEL_SVH
`define QUANT_MODEL_SVH

// every sent block, 64 coefficients each in raster order (row*8 + col)
jpeg_quant_pkg::coef_t sent_coef [$];

// zig-zag rank to raster position
int zz_order [64];

// walk the diagonals, up-right on even ones and down-left on odd ones
function automatic void build_zz_order();
    int r;
    int c;
    r = 0;
    c = 0;
    for (int i = 0; i < 64; i++) begin
        zz_order[i] = r * 8 + c;
        if (((r + c) % 2) == 0) begin
            if (c == 7) begin
                r++;
            end else if (r == 0) begin
                c++;
            end else begin
                r--;
                c++;
            end
        end else begin
            if (r == 7) begin
                c++;
            end else if (c == 0) begin
                r++;
            end else begin
                r++;
                c--;
            end
        end
    end
endfunction

// reciprocal of the base entry, rounded to nearest
function automatic int recip(input bit chroma, input int pos);
    int b;
    if (chroma)
        b = int'(jpeg_quant_pkg::chroma_base[pos]);
    else
        b = int'(jpeg_quant_pkg::luma_base[pos]);
    return ((1 << `JQ_SHIFT) + b / 2) / b;
endfunction

// lane j of beat k in block b
function automatic logic signed [`JQ_QW-1:0] exp_coef(input int b, input int k, input int j);
    int pos;
    int a;
    int p;
    pos = zz_order[2 * k + j];
    a = int'(sent_coef[b * 64 + pos]);
    // blocks 4 and 5 of each mcu are chroma
    p = a * recip((b % 6) >= 4, pos);
    p = p >>> `JQ_SHIFT;
    return p[`JQ_QW-1:0];
endfunction

function automatic jpeg_quant_pkg::blk_tag_t exp_tag(input int b, input int k, input int mcus);
    jpeg_quant_pkg::blk_tag_t t;
    t.pair_idx = 5'(k);
    case (b % 6)
        4:       t.plane = jpeg_quant_pkg::PLANE_U;
        5:       t.plane = jpeg_quant_pkg::PLANE_V;
        default: t.plane = jpeg_quant_pkg::PLANE_Y;
    endcase
    t.last_mcu = ((b % 6) == 5) && (((b / 6) % mcus) == mcus - 1);
    return t;
endfunction

`endif

// File: tb/quant_tb.sv
// quantizer testbench, random blocks and back-pressure checked against a reference model
`timescale 1ns/10ps
`include "jpeg_quant_macros.svh"

module quant_tb;

    localparam int n_blocks = 24;
    localparam int beats = 32;
    localparam int x_size = 31;
    localparam int y_size = 15;
    localparam int mcus_per_frame = ((x_size >> 4) + 1) * ((y_size >> 4) + 1);
    localparam int n_frames = n_blocks / (6 * mcus_per_frame);
    localparam int cycle_limit = n_blocks * 40 * 3 + 200;

    logic                           clk;
    logic                           resetn;
    jpeg_quant_pkg::col_t           di;
    logic                           di_valid;
    logic [2:0]                     di_cnt;
    logic                           di_hold;
    jpeg_quant_pkg::qpair_t         q;
    logic                           q_valid;
    logic                           q_hold;
    jpeg_quant_pkg::blk_tag_t       q_tag;
    logic [`JQ_XW-1:0]              x_size_m1;
    logic [`JQ_YW-1:0]              y_size_m1;

    logic [31:0]                    lfsr_state;
    jpeg_quant_pkg::coef_t          stim [n_blocks*64];
    logic                           hold_en;
    int                             value_errors;
    int                             count_errors;
    int                             beat_cnt;
    int                             last_cnt;
    int                             cycle_cnt;

    `include "quant_model.svh"

    quant quant_inst (
        .clk       (clk),
        .resetn    (resetn),
        .di        (di),
        .di_valid  (di_valid),
        .di_cnt    (di_cnt),
        .di_hold   (di_hold),
        .q         (q),
        .q_valid   (q_valid),
        .q_hold    (q_hold),
        .q_tag     (q_tag),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [`JQ_DW-1:0] rand_word();
        logic [`JQ_DW-1:0] w;
        for (int i = 0; i < `JQ_DW; i++)
            w[i] = next_bit();
        return w;
    endfunction

    // a column stays on di until the buffer takes it
    task automatic send_block(input int b);
        jpeg_quant_pkg::col_t col;
        for (int i = 0; i < 64; i++)
            sent_coef.push_back(stim[b * 64 + i]);
        for (int c = 0; c < 8; c++) begin
            for (int r = 0; r < 8; r++)
                col[r] = stim[b * 64 + r * 8 + c];
            di       <= col;
            di_valid <= 1'b1;
            di_cnt   <= 3'(c);
            @(posedge clk);
            while (di_hold)
                @(posedge clk);
        end
    endtask

    task automatic check_beat();
        int                         b;
        int                         k;
        logic signed [`JQ_QW-1:0]   ev;
        jpeg_quant_pkg::blk_tag_t   et;
        b = beat_cnt / beats;
        k = beat_cnt % beats;
        if (b >= sent_coef.size() / 64) begin
            $display("output beat %0d arrived but only %0d blocks were sent",
                     beat_cnt, sent_coef.size() / 64);
            count_errors++;
        end else begin
            for (int j = 0; j < 2; j++) begin
                ev = exp_coef(b, k, j);
                if (q[j] !== ev) begin
                    $display("** Error at %0t: block %0d beat %0d lane %0d q=%0d expected %0d",
                             $time, b, k, j, q[j], ev);
                    value_errors++;
                end
            end
            et = exp_tag(b, k, mcus_per_frame);
            if (q_tag !== et) begin
                $display("** Error at %0t: block %0d beat %0d tag %0d/%0d/%0d expected %0d/%0d/%0d",
                         $time, b, k, q_tag.last_mcu, q_tag.plane, q_tag.pair_idx,
                         et.last_mcu, et.plane, et.pair_idx);
                value_errors++;
            end
            if (q_tag.last_mcu)
                last_cnt++;
        end
        beat_cnt++;
    endtask

    // a beat is taken on every edge with q_valid high and q_hold low
    always @(posedge clk) begin
        if (resetn && q_valid && !q_hold)
            check_beat();
    end

    // random back-pressure, one cycle in four on average
    always @(posedge clk) begin
        if (hold_en)
            q_hold <= next_bit() & next_bit();
        else
            q_hold <= 1'b0;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("value errors %0d, count errors %0d", value_errors, count_errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        resetn       = 1'b0;
        di           = '0;
        di_valid     = 1'b0;
        di_cnt       = '0;
        q_hold       = 1'b0;
        x_size_m1    = x_size;
        y_size_m1    = y_size;
        hold_en      = 1'b0;
        value_errors = 0;
        count_errors = 0;
        beat_cnt     = 0;
        last_cnt     = 0;
        cycle_cnt    = 0;
        lfsr_state   = 32'd69;
        build_zz_order();
        for (int i = 0; i < n_blocks * 64; i++)
            stim[i] = jpeg_quant_pkg::coef_t'(rand_word());

        repeat (4) @(posedge clk);
        resetn  <= 1'b1;
        hold_en <= 1'b1;

        for (int b = 0; b < n_blocks; b++)
            send_block(b);
        di_valid <= 1'b0;

        // drain the pipeline, then watch for stray beats
        while (beat_cnt < n_blocks * beats)
            @(posedge clk);
        hold_en <= 1'b0;
        repeat (20) @(posedge clk);

        if (beat_cnt != n_blocks * beats) begin
            $display("received %0d beats but %0d were expected", beat_cnt, n_blocks * beats);
            count_errors++;
        end
        if (last_cnt != beats * n_frames) begin
            $display("last-MCU flag was seen on %0d beats, expected %0d",
                     last_cnt, beats * n_frames);
            count_errors++;
        end

        $display("value errors %0d, count errors %0d", value_errors, count_errors);
        if (value_errors + count_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
